// ==== design/fetch_config.svh ====
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// ##################################################
// parcel buffer geometry

// number of 16-bit slots that hold two memory words
`define PARCEL_BUF_DEPTH 4

// the free counter must hold the full depth and needs log2(depth) + 1 bits
`define PARCEL_BUF_CNT_W 3

// ##################################################
// fetch start

// pc the fetch unit starts from when reset is released
`define FETCH_RESET_PC 32'h0000_0000

`endif

// ==== design/fetch_pkg.sv ====
`include "fetch_config.svh"

package fetch_pkg;

    // one 16-bit instruction parcel
    typedef logic [15:0] parcel_t;

    // one instruction memory word
    typedef logic [31:0] word_t;

    // byte address, also used for the pc
    typedef logic [31:0] addr_t;

    // free slots in the parcel buffer
    typedef logic [`PARCEL_BUF_CNT_W-1:0] free_cnt_t;

    // issued instruction with only the low parcel kept in instr when compressed
    typedef struct packed
    {
        addr_t pc;
        word_t instr;
        logic  compressed;
        logic  illegal;
    } instr_pkt_t;

    // request tracking in the fetch controller
    typedef enum logic [1:0]
    {
        FETCH_IDLE,
        FETCH_WAIT,
        FETCH_DISCARD
    } fetch_state_t;

endpackage

// ==== design/fetch_ctrl.sv ====
`timescale 1ns/1ps

`include "fetch_config.svh"

module fetch_ctrl
(
    input  logic                 i_clk,
    input  logic                 i_reset_n,
    input  logic                 i_redirect,
    input  fetch_pkg::addr_t     i_redirect_pc,
    input  logic                 i_mem_ack,
    input  fetch_pkg::free_cnt_t i_free_cnt,
    output logic                 o_mem_req,
    output fetch_pkg::addr_t     o_mem_addr,
    output logic                 o_push,
    output logic                 o_push_half,
    output logic                 o_flush,
    output fetch_pkg::addr_t     o_flush_pc
);

    import fetch_pkg::*;

    fetch_state_t state;
    fetch_state_t state_nxt;
    addr_t        fetch_pc;
    logic         fetch_en;
    logic         req_half;
    free_cnt_t    need;

    // a halfword-aligned pc only brings the upper parcel of its word
    assign need = fetch_pc[1] ? free_cnt_t'(1) : free_cnt_t'(2);

    // fetch_en holds off requests until the first cycle out of reset
    assign o_mem_req = fetch_en && (state == FETCH_IDLE) && !i_redirect
                       && (i_free_cnt >= need);
    assign o_mem_addr = {fetch_pc[31:2], 2'b00};

    assign o_push      = i_mem_ack && (state == FETCH_WAIT) && !i_redirect;
    assign o_push_half = req_half;
    assign o_flush     = i_redirect;
    assign o_flush_pc  = i_redirect_pc;

    // ##################################################
    // request tracking

    always_comb
    begin
        state_nxt = state;
        case (state)
            FETCH_IDLE:
            begin
                if (o_mem_req)
                    state_nxt = FETCH_WAIT;
            end
            FETCH_WAIT:
            begin
                // an ack together with the redirect is simply not pushed
                if (i_mem_ack)
                    state_nxt = FETCH_IDLE;
                else if (i_redirect)
                    state_nxt = FETCH_DISCARD;
            end
            FETCH_DISCARD:
            begin
                if (i_mem_ack)
                    state_nxt = FETCH_IDLE;
            end
            default:
                state_nxt = FETCH_IDLE;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            state    <= FETCH_IDLE;
            fetch_pc <= `FETCH_RESET_PC;
            fetch_en <= 1'b0;
            req_half <= 1'b0;
        end
        else
        begin
            state    <= state_nxt;
            fetch_en <= 1'b1;
            if (i_redirect)
                fetch_pc <= i_redirect_pc;
            else if (o_mem_req)
            begin
                // both cases continue at the next word boundary
                fetch_pc <= {fetch_pc[31:2], 2'b00} + addr_t'(4);
                req_half <= fetch_pc[1];
            end
        end
    end

    // ##################################################
    // checks

    // once a request is out, the next one waits for its ack
    a_one_outstanding: assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        o_mem_req |=> (!o_mem_req until_with i_mem_ack)
    );

    // a response overtaken by a redirect never reaches the buffer
    a_drop_stale: assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        (i_redirect && (state != FETCH_IDLE)) |-> (!o_push until_with i_mem_ack)
    );

endmodule

// ==== design/parcel_buf.sv ====
`timescale 1ns/1ps

`include "fetch_config.svh"

module parcel_buf
(
    input  logic                 i_clk,
    input  logic                 i_reset_n,
    input  logic                 i_push,
    input  logic                 i_push_half,
    input  fetch_pkg::word_t     i_data,
    input  logic                 i_flush,
    input  fetch_pkg::addr_t     i_flush_pc,
    output fetch_pkg::free_cnt_t o_free_cnt,
    output logic                 o_pop,
    output fetch_pkg::addr_t     o_pop_pc,
    output fetch_pkg::word_t     o_pop_word
);

    import fetch_pkg::*;

    localparam free_cnt_t DEPTH = free_cnt_t'(`PARCEL_BUF_DEPTH);

    parcel_t   slots     [`PARCEL_BUF_DEPTH];
    parcel_t   slots_nxt [`PARCEL_BUF_DEPTH];
    free_cnt_t free_cnt;
    free_cnt_t used;
    free_cnt_t push_n;
    free_cnt_t pop_n;
    free_cnt_t wr_idx;
    addr_t     head_pc;
    logic      head_comp;

    // slot 0 is always the head and occupied slots are packed toward it
    assign used      = DEPTH - free_cnt;
    assign head_comp = (slots[0][1:0] != 2'b11);

    // ##################################################
    // pop and push sizes

    // a full-length instruction leaves only once both of its parcels are in
    assign o_pop = head_comp ? (used != '0) : (used >= free_cnt_t'(2));

    assign pop_n = !o_pop ? '0
                 : (head_comp ? free_cnt_t'(1) : free_cnt_t'(2));

    assign push_n = !i_push ? '0
                  : (i_push_half ? free_cnt_t'(1) : free_cnt_t'(2));

    // pushed parcels land right behind whatever survives this cycle's pop
    assign wr_idx = used - pop_n;

    // ##################################################
    // slot update

    always_comb
    begin
        slots_nxt = slots;
        for (int i = 0; i < `PARCEL_BUF_DEPTH; i++)
        begin
            if (i + int'(pop_n) < `PARCEL_BUF_DEPTH)
                slots_nxt[i] = slots[i + int'(pop_n)];

            // after a halfword redirect only the upper parcel is wanted
            if (i_push && (free_cnt_t'(i) == wr_idx))
                slots_nxt[i] = i_push_half ? i_data[31:16] : i_data[15:0];

            if (i_push && !i_push_half && (free_cnt_t'(i) == wr_idx + free_cnt_t'(1)))
                slots_nxt[i] = i_data[31:16];
        end
    end

    always_ff @(posedge i_clk)
    begin
        slots <= slots_nxt;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            free_cnt <= DEPTH;
            head_pc  <= `FETCH_RESET_PC;
        end
        else if (i_flush)
        begin
            free_cnt <= DEPTH;
            head_pc  <= i_flush_pc;
        end
        else
        begin
            free_cnt <= free_cnt - push_n + pop_n;
            head_pc  <= head_pc + (addr_t'(pop_n) << 1);
        end
    end

    assign o_free_cnt = free_cnt;
    assign o_pop_pc   = head_pc;
    assign o_pop_word = {slots[1], slots[0]};

    // ##################################################
    // checks

    // the controller sized its request against an older free count
    a_no_overfill: assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        i_push |-> (push_n <= free_cnt)
    );

    a_free_bound: assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        free_cnt <= DEPTH
    );

endmodule

// ==== design/instr_issue.sv ====
`timescale 1ns/1ps

module instr_issue
(
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  logic                  i_flush,
    input  logic                  i_pop,
    input  fetch_pkg::addr_t      i_pop_pc,
    input  fetch_pkg::word_t      i_pop_word,
    output logic                  o_instr_valid,
    output fetch_pkg::instr_pkt_t o_instr
);

    import fetch_pkg::*;

    instr_pkt_t pkt_nxt;
    instr_pkt_t pkt;
    logic       valid;
    logic       comp;

    assign comp = (i_pop_word[1:0] != 2'b11);

    always_comb
    begin
        pkt_nxt.pc         = i_pop_pc;
        pkt_nxt.compressed = comp;
        // the next parcel may belong to another instruction, so hide it
        pkt_nxt.instr      = comp ? {16'h0000, i_pop_word[15:0]} : i_pop_word;
        // an all-zero parcel is the defined illegal encoding
        pkt_nxt.illegal    = (i_pop_word[15:0] == 16'h0000);
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            valid <= 1'b0;
        else
            valid <= i_pop && !i_flush;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_pop)
            pkt <= pkt_nxt;
    end

    assign o_instr_valid = valid;
    assign o_instr       = pkt;

    // redirect targets and pc steps are all in halfwords
    a_pc_aligned: assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        o_instr_valid |-> (o_instr.pc[0] == 1'b0)
    );

endmodule

// ==== design/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top
(
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  logic                  i_redirect,
    input  fetch_pkg::addr_t      i_redirect_pc,
    output logic                  o_mem_req,
    output fetch_pkg::addr_t      o_mem_addr,
    input  logic                  i_mem_ack,
    input  fetch_pkg::word_t      i_mem_data,
    output logic                  o_instr_valid,
    output fetch_pkg::instr_pkt_t o_instr
);

    import fetch_pkg::*;

    logic      push;
    logic      push_half;
    logic      flush;
    addr_t     flush_pc;
    free_cnt_t free_cnt;
    logic      pop;
    addr_t     pop_pc;
    word_t     pop_word;

    // ##################################################
    // memory side

    fetch_ctrl i_fetch_ctrl
    (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .i_mem_ack     (i_mem_ack),
        .i_free_cnt    (free_cnt),
        .o_mem_req     (o_mem_req),
        .o_mem_addr    (o_mem_addr),
        .o_push        (push),
        .o_push_half   (push_half),
        .o_flush       (flush),
        .o_flush_pc    (flush_pc)
    );

    // memory data goes straight to the buffer, qualified by push
    parcel_buf i_parcel_buf
    (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_push      (push),
        .i_push_half (push_half),
        .i_data      (i_mem_data),
        .i_flush     (flush),
        .i_flush_pc  (flush_pc),
        .o_free_cnt  (free_cnt),
        .o_pop       (pop),
        .o_pop_pc    (pop_pc),
        .o_pop_word  (pop_word)
    );

    // ##################################################
    // issue side

    instr_issue i_instr_issue
    (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_flush       (flush),
        .i_pop         (pop),
        .i_pop_pc      (pop_pc),
        .i_pop_word    (pop_word),
        .o_instr_valid (o_instr_valid),
        .o_instr       (o_instr)
    );

endmodule

// ==== verif/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb;

    import fetch_pkg::*;

    // worst random latency and the cycle budgets derived from it
    localparam int RAND_LAT_MAX = 8;
    localparam int PKT_WAIT     = RAND_LAT_MAX * 4 + 20;

    logic       i_clk;
    logic       i_reset_n;
    logic       i_redirect;
    addr_t      i_redirect_pc;
    logic       o_mem_req;
    addr_t      o_mem_addr;
    logic       i_mem_ack;
    word_t      i_mem_data;
    logic       o_instr_valid;
    instr_pkt_t o_instr;

    // tests as read from the data file with memory and expected entries kept flat
    addr_t      t_pc [$];
    int         t_lat [$];
    int         t_nw [$];
    int         t_ne [$];
    int         m_first [$];
    int         e_first [$];
    addr_t      m_addr [$];
    word_t      m_data [$];
    instr_pkt_t e_pkt [$];
    instr_pkt_t got_q [$];

    int          img_lo;
    int          img_n;
    int          cur_lat;
    logic        redirected;
    logic [31:0] lfsr;
    int          watch_cycles;
    int          value_errs;
    int          missing_errs;
    int          extra_errs;

    fetch_top i_dut
    (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .o_mem_req     (o_mem_req),
        .o_mem_addr    (o_mem_addr),
        .i_mem_ack     (i_mem_ack),
        .i_mem_data    (i_mem_data),
        .o_instr_valid (o_instr_valid),
        .o_instr       (o_instr)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic next_lfsr_bit();
        logic b;
        b    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], b};
        return b;
    endfunction

    function automatic int pick_latency();
        logic [2:0] r;
        if (cur_lat != 0)
            return cur_lat;
        for (int i = 0; i < 3; i++)
            r[i] = next_lfsr_bit();
        return 1 + int'(r);
    endfunction

    function automatic logic find_word(input addr_t a, output word_t d);
        d = '0;
        for (int i = img_lo; i < img_lo + img_n; i++)
        begin
            if (m_addr[i] == a)
            begin
                d = m_data[i];
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // ##################################################
    // memory model and packet collector

    // a word outside the image is held back until the next redirect makes it stale
    initial
    begin
        addr_t req_addr;
        word_t data;
        int    lat;
        int    waited;
        logic  hit;
        logic  done;
        i_mem_ack  = 1'b0;
        i_mem_data = '0;
        forever
        begin
            @(negedge i_clk);
            if (i_reset_n && o_mem_req)
            begin
                req_addr   = o_mem_addr;
                redirected = 1'b0;
                lat        = pick_latency();
                waited     = 0;
                done       = 1'b0;
                while (!done)
                begin
                    @(posedge i_clk);
                    waited++;
                    hit = find_word(req_addr, data);
                    if (redirected)
                    begin
                        data = ~req_addr ^ 32'h5a5a_a5a5;
                        done = 1'b1;
                    end
                    else if (hit && waited >= lat)
                        done = 1'b1;
                end
                #1;
                i_mem_ack  = 1'b1;
                i_mem_data = data;
                @(posedge i_clk);
                #1;
                i_mem_ack = 1'b0;
            end
        end
    end

    always @(negedge i_clk)
    begin
        if (i_reset_n && o_instr_valid)
            got_q.push_back(o_instr);
    end

    initial
    begin
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge i_clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", watch_cycles);
        $display("Checks failed");
        $finish;
    end

    // ##################################################
    // test sequence

    initial
    begin
        int               fd;
        int               rc;
        int               lat;
        int               nw;
        int               ne;
        int               max_lat;
        int               waited;
        addr_t            pc;
        addr_t            a;
        word_t            w;
        logic             c;
        logic             il;
        logic [8*160-1:0] line;
        instr_pkt_t       p;
        instr_pkt_t       exp;
        i_reset_n     = 1'b0;
        i_redirect    = 1'b0;
        i_redirect_pc = '0;
        lfsr          = 32'h19623eed;
        img_lo        = 0;
        img_n         = 0;
        cur_lat       = 1;
        redirected    = 1'b0;
        watch_cycles  = 0;
        value_errs    = 0;
        missing_errs  = 0;
        extra_errs    = 0;
        max_lat       = 1;

        fd = $fopen("verif/fetch_tests.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the tests file verif/fetch_tests.txt");
        end
        else
        begin
            rc = $fgets(line, fd);
            rc = $fgets(line, fd);
            while ($fscanf(fd, "%h %d %d %d", pc, lat, nw, ne) == 4)
            begin
                t_pc.push_back(pc);
                t_lat.push_back(lat);
                t_nw.push_back(nw);
                t_ne.push_back(ne);
                m_first.push_back(m_addr.size());
                e_first.push_back(e_pkt.size());
                max_lat = (lat == 0) ? RAND_LAT_MAX : ((lat > max_lat) ? lat : max_lat);
                repeat (nw)
                begin
                    rc = $fscanf(fd, "%h %h", a, w);
                    m_addr.push_back(a);
                    m_data.push_back(w);
                end
                repeat (ne)
                begin
                    rc = $fscanf(fd, "%h %h %b %b", a, w, c, il);
                    p.pc         = a;
                    p.instr      = w;
                    p.compressed = c;
                    p.illegal    = il;
                    e_pkt.push_back(p);
                end
            end
            $fclose(fd);
        end
        assert (t_pc.size() > 0)
        else
        begin
            missing_errs++;
            $display("The tests file holds no tests");
        end
        watch_cycles = e_pkt.size() * max_lat * 4 + t_pc.size() * 200 + 50;

        repeat (3) @(posedge i_clk);
        #1;
        i_reset_n = 1'b1;

        for (int t = 0; t < t_pc.size(); t++)
        begin
            @(posedge i_clk);
            #1;
            img_lo        = m_first[t];
            img_n         = t_nw[t];
            cur_lat       = t_lat[t];
            redirected    = 1'b1;
            got_q.delete();
            i_redirect    = 1'b1;
            i_redirect_pc = t_pc[t];
            @(posedge i_clk);
            #1;
            i_redirect = 1'b0;
            for (int k = 0; k < t_ne[t]; k++)
            begin
                waited = 0;
                while (got_q.size() <= k && waited < PKT_WAIT)
                begin
                    @(posedge i_clk);
                    waited++;
                end
                exp = e_pkt[e_first[t] + k];
                assert (got_q.size() > k)
                else
                begin
                    missing_errs++;
                    $display("Test %0d: packet %0d at pc %h never arrived", t, k, exp.pc);
                    break;
                end
                assert (got_q[k] === exp)
                else
                begin
                    value_errs++;
                    $display(
                        "Fail at %0t: test %0d packet %0d got %h %h %b%b, expected %h %h %b%b",
                        $time, t, k, got_q[k].pc, got_q[k].instr, got_q[k].compressed,
                        got_q[k].illegal, exp.pc, exp.instr, exp.compressed, exp.illegal);
                end
            end
            repeat (PKT_WAIT) @(posedge i_clk);
            assert (got_q.size() <= t_ne[t])
            else
            begin
                extra_errs++;
                $display("Test %0d: %0d packets issued beyond the expected stream",
                         t, got_q.size() - t_ne[t]);
            end
        end

        $display("errors: value %0d, missing %0d, extra %0d", value_errs, missing_errs, extra_errs);
        if (value_errs + missing_errs + extra_errs == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// ==== verif/fetch_tests.txt ====
# per test: redirect_pc latency(0 = random) n_words n_expected, then n_words addr/data pairs,
# then n_expected lines of pc instr compressed illegal
00000100 1 3 3
00000100 00500093 00000104 00a00113 00000108 002081b3
00000100 00500093 0 0
00000104 00a00113 0 0
00000108 002081b3 0 0
00000200 2 3 5
00000200 45054501 00000204 00930485 00000208 80820010
00000200 00004501 1 0
00000202 00004505 1 0
00000204 00000485 1 0
00000206 00100093 0 0
0000020a 00008082 1 0
00000302 1 3 4
00000300 4785ffff 00000304 00f00293 00000308 853e4681
00000302 00004785 1 0
00000304 00f00293 0 0
00000308 00004681 1 0
0000030a 0000853e 1 0
00000400 3 1 1
00000400 05134405
00000400 00004405 1 0
00000500 2 1 2
00000500 45010000
00000500 00000000 1 1
00000502 00004501 1 0
00000600 7 3 4
00000600 00934505 00000604 01130010 00000608 45010020
00000600 00004505 1 0
00000602 00100093 0 0
00000606 00200113 0 0
0000060a 00004501 1 0
00000700 0 3 4
00000700 00934505 00000704 01130010 00000708 45010020
00000700 00004505 1 0
00000702 00100093 0 0
00000706 00200113 0 0
0000070a 00004501 1 0

// ==== list.f ====
+incdir+design
design/fetch_pkg.sv
design/fetch_ctrl.sv
design/parcel_buf.sv
design/instr_issue.sv
design/fetch_top.sv
verif/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_frontend

sources:
  - include_dirs:
      - design
    files:
      - design/fetch_pkg.sv
      - design/fetch_ctrl.sv
      - design/parcel_buf.sv
      - design/instr_issue.sv
      - design/fetch_top.sv
  - target: simulation
    files:
      - verif/fetch_tb.sv
